//--- src/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int PPN_W      = 22;

    typedef enum logic [3:0] {
        CSR_CMD_NONE       = 4'd0,
        CSR_CMD_READ       = 4'd1,
        CSR_CMD_WRITE      = 4'd2,
        CSR_CMD_READ_WRITE = 4'd3,
        CSR_CMD_READ_SET   = 4'd4,
        CSR_CMD_READ_CLEAR = 4'd5
    } csr_cmd_e;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3  // 2 is reserved
    } priv_e;

    // Read-only space has the top two address bits set
    localparam logic [CSR_ADDR_W-1:0] CSR_MCUR_PRIV = 12'hFC0;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;

    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;

    localparam logic [CSR_ADDR_W-1:0] CSR_STVEC     = 12'h105;
    localparam logic [CSR_ADDR_W-1:0] CSR_SSCRATCH  = 12'h140;
    localparam logic [CSR_ADDR_W-1:0] CSR_SEPC      = 12'h141;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCAUSE    = 12'h142;
    localparam logic [CSR_ADDR_W-1:0] CSR_STVAL     = 12'h143;
    localparam logic [CSR_ADDR_W-1:0] CSR_SATP      = 12'h180;

    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH    = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH  = 12'hB82;

    localparam int MSTATUS_TSR    = 22;
    localparam int MSTATUS_TW     = 21;
    localparam int MSTATUS_TVM    = 20;
    localparam int MSTATUS_MXR    = 19;
    localparam int MSTATUS_SUM    = 18;
    localparam int MSTATUS_MPRV   = 17;
    localparam int MSTATUS_MPP_HI = 12;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_SPP    = 8;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_SPIE   = 5;
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_SIE    = 1;

    typedef struct packed {
        csr_cmd_e              cmd;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic                  en;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        logic             satp_mode;
        logic [PPN_W-1:0] satp_ppn;
        logic             mprv;
        logic             mxr;
        logic             sum;
        logic [1:0]       mpp;
    } mem_ctrl_t;

    typedef struct packed {
        logic tsr;
        logic tw;
        logic tvm;
    } trap_ctrl_t;

endpackage

//--- src/csr_access_check.sv
`timescale 1ns/1ps

module csr_access_check (
    input  csr_pkg::csr_req_t           req,
    input  csr_pkg::priv_e              priv,
    input  logic                        any_hit,
    input  logic [csr_pkg::XLEN-1:0]    readdata,
    output logic                        invalid,
    output csr_pkg::csr_wr_t            wr
);
    import csr_pkg::*;

    logic            is_read;
    logic            is_write;
    logic            is_access;
    logic            level_invalid;
    logic            ro_write;
    logic [XLEN-1:0] wr_value;

    assign is_read  = req.cmd inside {CSR_CMD_READ, CSR_CMD_READ_WRITE,
                                      CSR_CMD_READ_SET, CSR_CMD_READ_CLEAR};
    assign is_write = req.cmd inside {CSR_CMD_WRITE, CSR_CMD_READ_WRITE,
                                      CSR_CMD_READ_SET, CSR_CMD_READ_CLEAR};
    assign is_access = is_read || is_write;

    assign level_invalid = is_access && (2'(priv) < req.addr[9:8]);  // Bits 9..8 give min level
    assign ro_write      = is_write && (&req.addr[11:10]);

    // Unknown address only counts once level and space pass
    assign invalid = level_invalid || ro_write || (is_access && !any_hit);

    always_comb begin
        case (req.cmd)
            CSR_CMD_READ_SET:   wr_value = readdata | req.wdata;
            CSR_CMD_READ_CLEAR: wr_value = readdata & ~req.wdata;
            default:            wr_value = req.wdata;  // Write and read-write
        endcase
    end

    assign wr.en   = is_write && !invalid;
    assign wr.addr = req.addr;
    assign wr.data = wr_value;

endmodule

//--- src/csr_status_regs.sv
`timescale 1ns/1ps

module csr_status_regs #(
    parameter logic [csr_pkg::XLEN-1:0] MVENDORID = 32'h0A1AA1E0,
    parameter logic [csr_pkg::XLEN-1:0] MARCHID   = 32'h1,
    parameter logic [csr_pkg::XLEN-1:0] MIMPID    = 32'h1,
    parameter logic [csr_pkg::XLEN-1:0] MHARTID   = 32'h0
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   addr,
    input  csr_pkg::priv_e                   priv,
    input  csr_pkg::csr_wr_t                 wr,
    output logic                             hit,
    output logic [csr_pkg::XLEN-1:0]         rdata,
    output csr_pkg::mem_ctrl_t               mem_ctrl,
    output csr_pkg::trap_ctrl_t              trap_ctrl
);
    import csr_pkg::*;

    localparam logic [XLEN-1:0] MISA_BASE = 32'h40141100;  // RV32 with I, M, S, U

    mem_ctrl_t       mem_q;  // satp plus memory-access mstatus fields
    trap_ctrl_t      trap_q;
    logic            spp_q;
    logic            mpie_q;
    logic            spie_q;
    logic            mie_q;
    logic            sie_q;
    logic            misa_atomic_q;  // Scratch bit for atomic emulation
    logic [XLEN-1:0] mstatus_rd;

    always_comb begin
        mstatus_rd = '0;  // Unused bits stay zero
        mstatus_rd[MSTATUS_TSR]  = trap_q.tsr;
        mstatus_rd[MSTATUS_TW]   = trap_q.tw;
        mstatus_rd[MSTATUS_TVM]  = trap_q.tvm;
        mstatus_rd[MSTATUS_MXR]  = mem_q.mxr;
        mstatus_rd[MSTATUS_SUM]  = mem_q.sum;
        mstatus_rd[MSTATUS_MPRV] = mem_q.mprv;
        mstatus_rd[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mem_q.mpp;
        mstatus_rd[MSTATUS_SPP]  = spp_q;
        mstatus_rd[MSTATUS_MPIE] = mpie_q;
        mstatus_rd[MSTATUS_SPIE] = spie_q;
        mstatus_rd[MSTATUS_MIE]  = mie_q;
        mstatus_rd[MSTATUS_SIE]  = sie_q;
    end

    always_comb begin
        hit = 1'b1;
        case (addr)
            CSR_MCUR_PRIV: rdata = {{(XLEN-2){1'b0}}, priv};
            CSR_MVENDORID: rdata = MVENDORID;
            CSR_MARCHID:   rdata = MARCHID;
            CSR_MIMPID:    rdata = MIMPID;
            CSR_MHARTID:   rdata = MHARTID;
            CSR_MSTATUS:   rdata = mstatus_rd;
            CSR_MISA:      rdata = MISA_BASE | {{(XLEN-1){1'b0}}, misa_atomic_q};
            CSR_SATP:      rdata = {mem_q.satp_mode, {(XLEN-1-PPN_W){1'b0}}, mem_q.satp_ppn};
            default: begin
                hit   = 1'b0;
                rdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_q         <= '0;
            trap_q        <= '0;
            spp_q         <= 1'b0;
            mpie_q        <= 1'b0;
            spie_q        <= 1'b0;
            mie_q         <= 1'b0;
            sie_q         <= 1'b0;
            misa_atomic_q <= 1'b0;
        end else if (wr.en) begin
            case (wr.addr)
                CSR_MSTATUS: begin
                    trap_q.tsr <= wr.data[MSTATUS_TSR];
                    trap_q.tw  <= wr.data[MSTATUS_TW];
                    trap_q.tvm <= wr.data[MSTATUS_TVM];
                    mem_q.mxr  <= wr.data[MSTATUS_MXR];
                    mem_q.sum  <= wr.data[MSTATUS_SUM];
                    mem_q.mprv <= wr.data[MSTATUS_MPRV];
                    if (wr.data[MSTATUS_MPP_HI:MSTATUS_MPP_LO] != 2'b10)  // Reserved level
                        mem_q.mpp <= wr.data[MSTATUS_MPP_HI:MSTATUS_MPP_LO];
                    spp_q      <= wr.data[MSTATUS_SPP];
                    mpie_q     <= wr.data[MSTATUS_MPIE];
                    spie_q     <= wr.data[MSTATUS_SPIE];
                    mie_q      <= wr.data[MSTATUS_MIE];
                    sie_q      <= wr.data[MSTATUS_SIE];
                end
                CSR_MISA: misa_atomic_q <= wr.data[0];
                CSR_SATP: begin
                    mem_q.satp_mode <= wr.data[XLEN-1];
                    mem_q.satp_ppn  <= wr.data[PPN_W-1:0];
                end
                default: ;
            endcase
        end
    end

    assign mem_ctrl  = mem_q;
    assign trap_ctrl = trap_q;

endmodule

//--- src/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   addr,
    input  csr_pkg::csr_wr_t                 wr,
    output logic                             hit,
    output logic [csr_pkg::XLEN-1:0]         rdata
);
    import csr_pkg::*;

    localparam int NUM_REGS = 10;

    // Machine set first and supervisor second in the same order
    localparam logic [CSR_ADDR_W-1:0] TRAP_ADDR [NUM_REGS] = '{
        CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL,
        CSR_STVEC, CSR_SSCRATCH, CSR_SEPC, CSR_SCAUSE, CSR_STVAL
    };

    // tvec and epc hold word addresses
    localparam logic [NUM_REGS-1:0] WORD_ALIGNED = 10'b00101_00101;

    logic [XLEN-1:0] regs_q [NUM_REGS];
    logic            misaligned;

    assign misaligned = |wr.data[1:0];

    always_comb begin
        hit   = 1'b0;
        rdata = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (addr == TRAP_ADDR[i]) begin
                hit   = 1'b1;
                rdata = regs_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs_q[i] <= '0;
        end else if (wr.en) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (wr.addr == TRAP_ADDR[i] && !(WORD_ALIGNED[i] && misaligned))
                    regs_q[i] <= wr.data;  // Misaligned vector writes are dropped
            end
        end
    end

endmodule

//--- src/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   addr,
    input  csr_pkg::csr_wr_t                 wr,
    input  logic                             instret_incr,
    output logic                             hit,
    output logic [csr_pkg::XLEN-1:0]         rdata
);
    import csr_pkg::*;

    logic [2*XLEN-1:0] cycle_q;
    logic [2*XLEN-1:0] instret_q;

    // A written half wins over the increment for that cycle
    function automatic logic [2*XLEN-1:0] count_next(
        input logic [2*XLEN-1:0] cur,
        input logic              inc,
        input logic              wr_lo,
        input logic              wr_hi,
        input logic [XLEN-1:0]   data
    );
        logic [2*XLEN-1:0] nxt;
        nxt = cur + (2*XLEN)'(inc);
        if (wr_lo)
            nxt = {cur[2*XLEN-1:XLEN], data};
        if (wr_hi)
            nxt = {data, cur[XLEN-1:0]};
        return nxt;
    endfunction

    always_comb begin
        hit = 1'b1;
        case (addr)
            CSR_CYCLE:    rdata = cycle_q[XLEN-1:0];
            CSR_CYCLEH:   rdata = cycle_q[2*XLEN-1:XLEN];
            CSR_INSTRET:  rdata = instret_q[XLEN-1:0];
            CSR_INSTRETH: rdata = instret_q[2*XLEN-1:XLEN];
            default: begin
                hit   = 1'b0;
                rdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q   <= count_next(cycle_q, 1'b1,
                                    wr.en && wr.addr == CSR_CYCLE,
                                    wr.en && wr.addr == CSR_CYCLEH, wr.data);
            instret_q <= count_next(instret_q, instret_incr,
                                    wr.en && wr.addr == CSR_INSTRET,
                                    wr.en && wr.addr == CSR_INSTRETH, wr.data);
        end
    end

endmodule

//--- src/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter logic [csr_pkg::XLEN-1:0] MVENDORID = 32'h0A1AA1E0,
    parameter logic [csr_pkg::XLEN-1:0] MARCHID   = 32'h1,
    parameter logic [csr_pkg::XLEN-1:0] MIMPID    = 32'h1,
    parameter logic [csr_pkg::XLEN-1:0] MHARTID   = 32'h0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  csr_pkg::csr_req_t            req,
    input  csr_pkg::priv_e               priv,
    input  logic                         instret_incr,
    output logic [csr_pkg::XLEN-1:0]     readdata,
    output logic                         invalid,
    output csr_pkg::mem_ctrl_t           mem_ctrl,
    output csr_pkg::trap_ctrl_t          trap_ctrl
);
    import csr_pkg::*;

    csr_wr_t         wr;  // Committed write that every bank sees
    logic            any_hit;
    logic            status_hit;
    logic            trap_hit;
    logic            cnt_hit;
    logic [XLEN-1:0] status_rdata;
    logic [XLEN-1:0] trap_rdata;
    logic [XLEN-1:0] cnt_rdata;

    // Banks drive zero on a miss
    assign readdata = status_rdata | trap_rdata | cnt_rdata;
    assign any_hit  = status_hit | trap_hit | cnt_hit;

    csr_access_check u_check (
        .req      (req),
        .priv     (priv),
        .any_hit  (any_hit),
        .readdata (readdata),
        .invalid  (invalid),
        .wr       (wr)
    );

    csr_status_regs #(
        .MVENDORID (MVENDORID),
        .MARCHID   (MARCHID),
        .MIMPID    (MIMPID),
        .MHARTID   (MHARTID)
    ) u_status (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (req.addr),
        .priv      (priv),
        .wr        (wr),
        .hit       (status_hit),
        .rdata     (status_rdata),
        .mem_ctrl  (mem_ctrl),
        .trap_ctrl (trap_ctrl)
    );

    csr_trap_regs u_trap (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (req.addr),
        .wr    (wr),
        .hit   (trap_hit),
        .rdata (trap_rdata)
    );

    csr_counters u_cnt (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (req.addr),
        .wr           (wr),
        .instret_incr (instret_incr),
        .hit          (cnt_hit),
        .rdata        (cnt_rdata)
    );

endmodule

//--- tb/csr_tb_cases.svh
// One row per step with name, cmd, addr, priv, opt, wdata, expected readdata and invalid
// opt bits choose random data checked by the model (RM), a model value (MD),
// instret_incr high (INC) or no readdata check (XRD)
task automatic build_cases();
    add_case("rst mstatus", RD, CSR_MSTATUS, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst satp", RD, CSR_SATP, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst mtvec", RD, CSR_MTVEC, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst sepc", RD, CSR_SEPC, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst mepc", RD, CSR_MEPC, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst mcause", RD, CSR_MCAUSE, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst stvec", RD, CSR_STVEC, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst scause", RD, CSR_SCAUSE, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst mscratch", RD, CSR_MSCRATCH, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("rst stval", RD, CSR_STVAL, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("rst instreth", RD, CSR_INSTRETH, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("rst cycleh", RD, CSR_CYCLEH, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("mvendorid", RD, CSR_MVENDORID, M, NO, 32'h0, ID_VENDOR, 1'b0);
    add_case("marchid", RD, CSR_MARCHID, M, NO, 32'h0, ID_ARCH, 1'b0);
    add_case("mimpid", RD, CSR_MIMPID, M, NO, 32'h0, ID_IMP, 1'b0);
    add_case("mhartid", RD, CSR_MHARTID, M, NO, 32'h0, ID_HART, 1'b0);
    add_case("misa", RD, CSR_MISA, M, NO, 32'h0, 32'h4014_1100, 1'b0);
    add_case("misa atomic wr", WR, CSR_MISA, M, NO, 32'h1, 32'h4014_1100, 1'b0);
    add_case("misa atomic rd", RD, CSR_MISA, M, NO, 32'h0, 32'h4014_1101, 1'b0);
    add_case("mvendorid wr", WR, CSR_MVENDORID, M, NO, 32'hdead, ID_VENDOR, 1'b1);
    add_case("mvendorid rd", RD, CSR_MVENDORID, M, NO, 32'h0, ID_VENDOR, 1'b0);
    add_case("mscratch wr", WR, CSR_MSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mscratch set", SET, CSR_MSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mscratch clr", CLR, CSR_MSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mscratch rd", RD, CSR_MSCRATCH, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("mtval wr", RW, CSR_MTVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mtval set", SET, CSR_MTVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mtval clr", CLR, CSR_MTVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("mtval rd", RD, CSR_MTVAL, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("sscratch wr", WR, CSR_SSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("sscratch set", SET, CSR_SSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("sscratch clr", CLR, CSR_SSCRATCH, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("sscratch rd", RD, CSR_SSCRATCH, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("stval wr", RW, CSR_STVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("stval set", SET, CSR_STVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("stval clr", CLR, CSR_STVAL, M, RM, 32'h0, 32'h0, 1'b0);
    add_case("stval rd", RD, CSR_STVAL, M, MD, 32'h0, 32'h0, 1'b0);
    add_case("mtvec wr", WR, CSR_MTVEC, M, NO, 32'h0000_1000, 32'h0, 1'b0);
    add_case("mtvec misalign", WR, CSR_MTVEC, M, NO, 32'h0000_2002, 32'h0000_1000, 1'b0);
    add_case("mtvec rd", RD, CSR_MTVEC, M, NO, 32'h0, 32'h0000_1000, 1'b0);
    add_case("sepc wr", WR, CSR_SEPC, M, NO, 32'h8000_0040, 32'h0, 1'b0);
    add_case("sepc misalign", WR, CSR_SEPC, M, NO, 32'h8000_0041, 32'h8000_0040, 1'b0);
    add_case("sepc rd", RD, CSR_SEPC, M, NO, 32'h0, 32'h8000_0040, 1'b0);
    add_case("mstatus wr", WR, CSR_MSTATUS, M, NO, 32'h807e_09ab, 32'h0, 1'b0);
    add_case("mstatus rd", RD, CSR_MSTATUS, M, NO, 32'h0, 32'h007e_09aa, 1'b0);
    add_case("mstatus mpp2", WR, CSR_MSTATUS, M, NO, 32'h0004_1000, 32'h007e_09aa, 1'b0);
    add_case("mstatus rd2", RD, CSR_MSTATUS, M, NO, 32'h0, 32'h0004_0800, 1'b0);
    add_case("satp wr", WR, CSR_SATP, M, NO, 32'hffd2_3456, 32'h0, 1'b0);
    add_case("satp rd", RD, CSR_SATP, M, NO, 32'h0, 32'h8012_3456, 1'b0);
    add_case("mstatus user rd", RD, CSR_MSTATUS, U, NO, 32'h0, 32'h0004_0800, 1'b1);
    add_case("mstatus user wr", WR, CSR_MSTATUS, U, NO, 32'hffff_ffff, 32'h0004_0800, 1'b1);
    add_case("sscratch user wr", WR, CSR_SSCRATCH, U, MD, 32'h1111_1111, 32'h0, 1'b1);
    add_case("mstatus kept", RD, CSR_MSTATUS, M, NO, 32'h0, 32'h0004_0800, 1'b0);
    add_case("sscratch sup wr", WR, CSR_SSCRATCH, S, RM, 32'h0, 32'h0, 1'b0);
    add_case("sscratch sup rd", RD, CSR_SSCRATCH, S, MD, 32'h0, 32'h0, 1'b0);
    add_case("priv user", RD, CSR_MCUR_PRIV, U, NO, 32'h0, 32'h0, 1'b1);
    add_case("priv machine", RD, CSR_MCUR_PRIV, M, NO, 32'h0, 32'h3, 1'b0);
    add_case("cycle wr", WR, CSR_CYCLE, M, XRD, 32'h1000_0000, 32'h0, 1'b0);
    add_case("cycle rd", RD, CSR_CYCLE, M, NO, 32'h0, 32'h1000_0000, 1'b0);
    add_case("cycle next", RD, CSR_CYCLE, M, NO, 32'h0, 32'h1000_0001, 1'b0);
    add_case("instret wr", WR, CSR_INSTRET, M, NO, 32'h50, 32'h0, 1'b0);
    add_case("instret hold", RD, CSR_INSTRET, M, NO, 32'h0, 32'h50, 1'b0);
    add_case("instret inc0", RD, CSR_INSTRET, M, INC, 32'h0, 32'h50, 1'b0);
    add_case("instret inc1", RD, CSR_INSTRET, M, INC, 32'h0, 32'h51, 1'b0);
    add_case("instret inc2", RD, CSR_INSTRET, M, INC, 32'h0, 32'h52, 1'b0);
    add_case("instret inc3", RD, CSR_INSTRET, M, NO, 32'h0, 32'h53, 1'b0);
    add_case("instret stop", RD, CSR_INSTRET, M, NO, 32'h0, 32'h53, 1'b0);
    add_case("unknown rd", RD, 12'h7c0, M, NO, 32'h0, 32'h0, 1'b1);
    add_case("unknown wr", WR, 12'h7c0, M, NO, 32'hffff, 32'h0, 1'b1);
    add_case("idle unknown", NOP, 12'h7c0, M, NO, 32'h0, 32'h0, 1'b0);
    add_case("idle mstatus", NOP, CSR_MSTATUS, M, NO, 32'h0, 32'h0004_0800, 1'b0);
endtask

//--- tb/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;

    localparam logic [XLEN-1:0] ID_VENDOR = 32'h0000_0612;
    localparam logic [XLEN-1:0] ID_ARCH   = 32'h0000_0023;
    localparam logic [XLEN-1:0] ID_IMP    = 32'h0001_0002;
    localparam logic [XLEN-1:0] ID_HART   = 32'h0000_0005;

    // Short names for the table
    localparam csr_cmd_e NOP = CSR_CMD_NONE;
    localparam csr_cmd_e RD  = CSR_CMD_READ;
    localparam csr_cmd_e WR  = CSR_CMD_WRITE;
    localparam csr_cmd_e RW  = CSR_CMD_READ_WRITE;
    localparam csr_cmd_e SET = CSR_CMD_READ_SET;
    localparam csr_cmd_e CLR = CSR_CMD_READ_CLEAR;
    localparam priv_e    U   = PRIV_USER;
    localparam priv_e    S   = PRIV_SUPERVISOR;
    localparam priv_e    M   = PRIV_MACHINE;

    localparam logic [3:0] NO  = 4'b0000;
    localparam logic [3:0] MD  = 4'b0010;
    localparam logic [3:0] RM  = 4'b0011;
    localparam logic [3:0] INC = 4'b0100;
    localparam logic [3:0] XRD = 4'b1000;

    typedef struct packed {
        csr_cmd_e              cmd;
        logic [CSR_ADDR_W-1:0] addr;
        priv_e                 priv;
        logic [3:0]            opt;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       rdata;
        logic                  invalid;
    } step_t;

    logic            clk;
    logic            rst_n;
    csr_req_t        req;
    priv_e           priv;
    logic            instret_incr;
    logic [XLEN-1:0] readdata;
    logic            invalid;
    mem_ctrl_t       mem_ctrl;
    trap_ctrl_t      trap_ctrl;

    step_t           steps[$];
    string           step_names[$];
    bit              table_ready;
    int              errors;
    int              failed_tests;
    logic [XLEN-1:0] model_q [logic [CSR_ADDR_W-1:0]];  // Scratch and tval values
    mem_ctrl_t       exp_mem;
    trap_ctrl_t      exp_trap;

    csr_file #(
        .MVENDORID (ID_VENDOR),
        .MARCHID   (ID_ARCH),
        .MIMPID    (ID_IMP),
        .MHARTID   (ID_HART)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .priv         (priv),
        .instret_incr (instret_incr),
        .readdata     (readdata),
        .invalid      (invalid),
        .mem_ctrl     (mem_ctrl),
        .trap_ctrl    (trap_ctrl)
    );

    task automatic add_case(
        input string                 name,
        input csr_cmd_e              cmd,
        input logic [CSR_ADDR_W-1:0] addr,
        input priv_e                 p,
        input logic [3:0]            opt,
        input logic [XLEN-1:0]       wdata,
        input logic [XLEN-1:0]       rdata,
        input logic                  inv
    );
        step_t s;
        s.cmd     = cmd;
        s.addr    = addr;
        s.priv    = p;
        s.opt     = opt;
        s.wdata   = wdata;
        s.rdata   = rdata;
        s.invalid = inv;
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    `include "csr_tb_cases.svh"

    task automatic compare_value(
        input string           name,
        input logic [XLEN-1:0] expected,
        input logic [XLEN-1:0] actual
    );
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
        if (model_q.exists(addr))
            return model_q[addr];
        return '0;  // Register still at reset value
    endfunction

    // Tracks what a committed write does to the status outputs
    task automatic commit_write(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] val);
        if (addr == CSR_MSTATUS) begin
            exp_trap.tsr = val[22];
            exp_trap.tw  = val[21];
            exp_trap.tvm = val[20];
            exp_mem.mxr  = val[19];
            exp_mem.sum  = val[18];
            exp_mem.mprv = val[17];
            if (val[12:11] != 2'b10)  // Reserved level keeps old mpp
                exp_mem.mpp = val[12:11];
        end
        if (addr == CSR_SATP) begin
            exp_mem.satp_mode = val[31];
            exp_mem.satp_ppn  = val[21:0];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (steps.size() + RESET_CYCLES + 20));
        $display("Watchdog: the run did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        step_t           s;
        string           name;
        logic [XLEN-1:0] wd;
        logic [XLEN-1:0] exp_rd;
        logic [XLEN-1:0] wval;
        int              errs_before;
        void'($urandom(32'h716b));
        rst_n        = 1'b0;
        req          = '0;
        priv         = PRIV_MACHINE;
        instret_incr = 1'b0;
        errors       = 0;
        failed_tests = 0;
        exp_mem      = '0;
        exp_trap     = '0;
        build_cases();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            s      = steps[i];
            name   = step_names[i];
            wd     = s.opt[0] ? $urandom : s.wdata;
            exp_rd = s.opt[1] ? model_read(s.addr) : s.rdata;
            req.cmd      = s.cmd;
            req.addr     = s.addr;
            req.wdata    = wd;
            priv         = s.priv;
            instret_incr = s.opt[2];
            #2;  // Outputs settle by mid low phase
            errs_before = errors;
            if (!s.opt[3])
                compare_value({name, " readdata"}, exp_rd, readdata);
            compare_value({name, " invalid"}, {31'b0, s.invalid}, {31'b0, invalid});
            compare_value({name, " ctrl"}, {1'b0, exp_mem, exp_trap},
                          {1'b0, mem_ctrl, trap_ctrl});
            if (s.cmd inside {WR, RW, SET, CLR} && !s.invalid) begin
                case (s.cmd)
                    SET:     wval = exp_rd | wd;
                    CLR:     wval = exp_rd & ~wd;
                    default: wval = wd;
                endcase
                if (s.opt[1])
                    model_q[s.addr] = wval;
                commit_write(s.addr, wval);
            end
            if (errors != errs_before)
                failed_tests++;
            $display("test %s %s", name, (errors == errs_before) ? "ok" : "mismatch");
        end

        @(negedge clk);
        req.cmd      = CSR_CMD_NONE;
        instret_incr = 1'b0;
        $display("%0d tests, %0d failed, %0d mismatches", steps.size(), failed_tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+tb
src/csr_pkg.sv
src/csr_access_check.sv
src/csr_status_regs.sv
src/csr_trap_regs.sv
src/csr_counters.sv
src/csr_file.sv
tb/csr_file_tb.sv

//--- run.sh
#!/bin/sh
# Builds the CSR file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module csr_file_tb \
    --Mdir obj_dir -o csr_file_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_file_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
